/* verilog/rom_pkg.sv */
/* rom subsystem package
   widths, divider ratio, controller states and bus structs */

package rom_pkg;

    // data and address widths of the prom
    localparam int ROM_DW = 8;
    localparam int ROM_AW = 10;

    // number of prom words
    localparam int ROM_WORDS = 2 ** ROM_AW;

    // byte count needs one more bit, it can reach ROM_WORDS
    localparam int ROM_CW = ROM_AW + 1;

    // saturation value of the byte count
    localparam logic [ROM_CW-1:0] COUNT_MAX = ROM_CW'(ROM_WORDS);

    // game side read enable, one clock in CEN_DIV
    localparam int CEN_DIV = 4;

    // width of the divider phase counter
    localparam int CEN_PW = $clog2(CEN_DIV);

    // controller states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        SCAN = 2'd2,
        RUN  = 2'd3
    } load_state_t;

    // host download port
    typedef struct packed {
        logic              active;  // high for the whole download
        logic              wr;      // one cycle per byte
        logic [ROM_DW-1:0] data;
    } dl_bus_t;

    // status word seen by the host and game side
    typedef struct packed {
        logic              busy;
        logic              ready;
        logic              overflow;  // sticky until next download
        logic [ROM_DW-1:0] sum;
        logic [ROM_CW-1:0] count;     // bytes loaded, saturating
    } rom_status_t;

endpackage

/* verilog/rom_prom.sv */
/* rom prom
   dual-port memory, full rate writes and enabled registered reads */

`timescale 1ns/1ps

module rom_prom
    import rom_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cen,
    input  logic              wr_en,
    input  logic [ROM_AW-1:0] wr_addr,
    input  logic [ROM_DW-1:0] wr_data,
    input  logic [ROM_AW-1:0] rd_addr,
    output logic [ROM_DW-1:0] q
);

    logic [ROM_DW-1:0] mem [0:ROM_WORDS-1];

    // write port ignores cen so downloads run at clock rate
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port
    // same edge read and write of one address returns the old word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (cen) begin
            q <= mem[rd_addr];
        end
        // q holds between enables
    end

endmodule

/* verilog/rom_addr_counter.sv */
/* rom address counter
   shared load and scan address with clear, step and wrap flag */

`timescale 1ns/1ps

module rom_addr_counter
    import rom_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              clear,
    input  logic              step,
    output logic [ROM_AW-1:0] addr,
    output logic              last
);

    logic [ROM_AW-1:0] base;
    logic [ROM_AW-1:0] addr_nxt;

    // clear first, then step
    // a byte taken together with clear lands on 0 and moves to 1
    always_comb begin
        base     = clear ? '0 : addr;
        addr_nxt = base + ROM_AW'(step);
    end

    // wraps from the top word back to 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr <= '0;
        end else begin
            addr <= addr_nxt;
        end
    end

    // top word, a write here wraps
    assign last = (addr == {ROM_AW{1'b1}});

endmodule

/* verilog/rom_cen_divider.sv */
/* rom clock enable divider
   free running phase counter, one cycle enable every CEN_DIV clocks */

`timescale 1ns/1ps

module rom_cen_divider
    import rom_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    output logic cen
);

    logic [CEN_PW-1:0] phase;

    // phase 0 out of reset
    // first enable on clock CEN_DIV
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= '0;
        end else if (cen) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // last phase of the period
    assign cen = (phase == CEN_PW'(CEN_DIV - 1));

endmodule

/* verilog/rom_sum_accum.sv */
/* rom checksum accumulator
   adds prom words one clock after each scan read, modulo 256 */

`timescale 1ns/1ps

module rom_sum_accum
    import rom_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              clear,
    input  logic              rd_issued,
    input  logic [ROM_DW-1:0] q,
    output logic [ROM_DW-1:0] sum
);

    // read issued last clock, q now holds its word
    logic rd_valid;

    // one cycle delay to match prom latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else if (clear) begin
            // pending read belongs to the old scan
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_issued;
        end
    end

    // sum wraps naturally at 8 bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum <= '0;
        end else if (clear) begin
            sum <= '0;
        end else if (rd_valid) begin
            sum <= sum + q;
        end
    end

endmodule

/* verilog/rom_load_ctrl.sv */
/* rom load controller
   idle, load, scan and run sequencing, prom read select and status */

`timescale 1ns/1ps

module rom_load_ctrl
    import rom_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  dl_bus_t           dl,
    input  logic [ROM_AW-1:0] rd_addr,
    input  logic              div_cen,
    input  logic [ROM_AW-1:0] cnt_addr,
    input  logic              cnt_last,
    input  logic [ROM_DW-1:0] sum,
    output logic              cnt_clear,
    output logic              cnt_step,
    output logic              prom_wr_en,
    output logic [ROM_AW-1:0] prom_rd_addr,
    output logic              prom_cen,
    output logic              acc_clear,
    output logic              rd_issued,
    output rom_status_t       status
);

    load_state_t       state;
    logic              active_q;
    logic              rise;
    logic              fall;
    logic              in_scan;
    logic              scan_done;
    logic [ROM_CW-1:0] count;
    logic [ROM_CW-1:0] scan_left;
    logic              ready;
    logic              overflow;

    // download edges
    assign rise = dl.active & ~active_q;
    assign fall = ~dl.active & active_q;

    // every strobe inside an active download is a write
    assign prom_wr_en = dl.active & dl.wr;

    assign in_scan = (state == SCAN);

    // one read per clock until count reads are out
    // a new download aborts the scan
    assign rd_issued = in_scan & (scan_left != '0) & ~rise;

    // last read has been issued, its word is still in flight
    assign scan_done = in_scan & (scan_left == '0) & ~rise;

    // counter restarts on download start, scan start and scan end
    // so it sits at 0 whenever the next download begins
    assign cnt_clear = rise | fall | scan_done;
    assign cnt_step  = prom_wr_en | rd_issued;

    assign acc_clear = rise;

    // scan owns the read port at full rate
    // game side reads follow the divider
    assign prom_rd_addr = in_scan ? cnt_addr : rd_addr;
    assign prom_cen     = in_scan | div_cen;

    // state register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            active_q <= 1'b0;
        end else begin
            active_q <= dl.active;
            if (rise) begin
                state <= LOAD;
            end else if (fall) begin
                state <= SCAN;
            end else if (scan_done) begin
                state <= RUN;
            end
        end
    end

    // loaded bytes, saturating at COUNT_MAX
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (rise) begin
            // a strobe in the start cycle already counts
            count <= prom_wr_en ? ROM_CW'(1) : '0;
        end else if (prom_wr_en && count != COUNT_MAX) begin
            count <= count + 1'b1;
        end
    end

    // sticky overflow, a write on the top word wraps
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            overflow <= 1'b0;
        end else if (rise) begin
            overflow <= 1'b0;
        end else if (prom_wr_en && cnt_last) begin
            overflow <= 1'b1;
        end
    end

    // reads left in the scan
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_left <= '0;
        end else if (fall) begin
            scan_left <= count;
        end else if (rd_issued) begin
            scan_left <= scan_left - 1'b1;
        end
    end

    // ready with the final addition, count+2 clocks after the fall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready <= 1'b0;
        end else if (rise) begin
            ready <= 1'b0;
        end else if (scan_done) begin
            ready <= 1'b1;
        end
    end

    // status word
    always_comb begin
        status.busy     = (state == LOAD) | in_scan;
        status.ready    = ready;
        status.overflow = overflow;
        status.sum      = sum;
        status.count    = count;
    end

endmodule

/* verilog/rom_subsys_top.sv */
/* rom subsystem top
   download, checksum scan and enabled playback around one prom */

`timescale 1ns/1ps

module rom_subsys_top
    import rom_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  dl_bus_t           dl,
    input  logic [ROM_AW-1:0] rd_addr,
    output logic [ROM_DW-1:0] q,
    output logic              cen,
    output rom_status_t       status
);

    // counter control
    logic              cnt_clear;
    logic              cnt_step;
    logic [ROM_AW-1:0] cnt_addr;
    logic              cnt_last;

    // prom control
    logic              prom_wr_en;
    logic [ROM_AW-1:0] prom_rd_addr;
    logic              prom_cen;

    // checksum path
    logic              acc_clear;
    logic              rd_issued;
    logic [ROM_DW-1:0] sum;

    rom_load_ctrl i_load_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .dl           (dl),
        .rd_addr      (rd_addr),
        .div_cen      (cen),
        .cnt_addr     (cnt_addr),
        .cnt_last     (cnt_last),
        .sum          (sum),
        .cnt_clear    (cnt_clear),
        .cnt_step     (cnt_step),
        .prom_wr_en   (prom_wr_en),
        .prom_rd_addr (prom_rd_addr),
        .prom_cen     (prom_cen),
        .acc_clear    (acc_clear),
        .rd_issued    (rd_issued),
        .status       (status)
    );

    // one counter serves both write and scan addresses
    rom_addr_counter i_addr_counter (
        .clk    (clk),
        .arst_n (arst_n),
        .clear  (cnt_clear),
        .step   (cnt_step),
        .addr   (cnt_addr),
        .last   (cnt_last)
    );

    // enable also goes out for the game logic
    rom_cen_divider i_cen_divider (
        .clk    (clk),
        .arst_n (arst_n),
        .cen    (cen)
    );

    rom_prom i_prom (
        .clk     (clk),
        .arst_n  (arst_n),
        .cen     (prom_cen),
        .wr_en   (prom_wr_en),
        .wr_addr (cnt_addr),
        .wr_data (dl.data),
        .rd_addr (prom_rd_addr),
        .q       (q)
    );

    rom_sum_accum i_sum_accum (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (acc_clear),
        .rd_issued (rd_issued),
        .q         (q),
        .sum       (sum)
    );

endmodule

/* testbench/tb_rom_subsys.sv */
/* rom subsystem testbench
   table driven downloads, scan timing and checksum, enabled playback */

`timescale 1ns/1ps

module tb_rom_subsys
    import rom_pkg::*;
;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_ROWS   = 5;
    localparam int NUM_READS  = 12;

    // one download case, byte count and data mode
    typedef struct packed {
        logic [10:0] len;
        logic        rnd;   // random bytes, else address pattern
    } case_t;

    // 200 bytes, shorter reload, empty, overflow, reload after overflow
    case_t cases [NUM_ROWS] = '{
        '{11'd200,  1'b1},
        '{11'd64,   1'b0},
        '{11'd0,    1'b1},
        '{11'd1030, 1'b1},
        '{11'd300,  1'b0}
    };

    logic              clk;
    logic              arst_n;
    dl_bus_t           dl;
    logic [ROM_AW-1:0] rd_addr;
    logic [ROM_DW-1:0] q;
    logic              cen;
    rom_status_t       status;

    // reference contents and highest address ever loaded
    logic [ROM_DW-1:0] model [ROM_WORDS];
    int                hi_mark;
    int unsigned       seed_val;

    rom_subsys_top i_rom_subsys_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .dl      (dl),
        .rd_addr (rd_addr),
        .q       (q),
        .cen     (cen),
        .status  (status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, got);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // fill pattern, mixes high index bits into the byte
    function automatic logic [ROM_DW-1:0] pattern_byte(input int idx);
        logic [31:0] u;
        u = idx;
        return u[7:0] ^ 8'(u[15:8] * 8'h25);
    endfunction

    // modulo 256 sum of the first cnt model words
    function automatic logic [ROM_DW-1:0] model_sum(input int cnt);
        logic [ROM_DW-1:0] s;
        s = '0;
        for (int i = 0; i < cnt; i++) begin
            s = s + model[ROM_AW'(i)];
        end
        return s;
    endfunction

    function automatic int total_bytes();
        int t;
        t = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            t = t + int'(cases[r].len);
        end
        return t;
    endfunction

    // one byte per clock, address wraps in the model like in the prom
    task automatic download(input int len, input logic rnd);
        logic [ROM_DW-1:0] b;
        dl.active = 1'b1;
        dl.wr     = 1'b0;
        @(negedge clk);
        // start of download clears the old status
        check_val("status.busy", 32'd1, 32'(status.busy));
        check_val("status.ready", 32'd0, 32'(status.ready));
        check_val("status.overflow", 32'd0, 32'(status.overflow));
        check_val("status.sum", 32'd0, 32'(status.sum));
        check_val("status.count", 32'd0, 32'(status.count));
        for (int i = 0; i < len; i++) begin
            b = rnd ? 8'($urandom) : pattern_byte(i);
            model[ROM_AW'(i)] = b;
            dl.wr   = 1'b1;
            dl.data = b;
            @(negedge clk);
            check_val("status.busy", 32'd1, 32'(status.busy));
        end
        dl.wr     = 1'b0;
        dl.active = 1'b0;
    endtask

    // ready exactly count+2 clocks after the fall
    task automatic scan_check(input int len);
        int exp_cnt;
        exp_cnt = (len > ROM_WORDS) ? ROM_WORDS : len;
        for (int n = 1; n <= exp_cnt + 2; n++) begin
            @(negedge clk);
            if (n < exp_cnt + 2) begin
                check_val("status.ready", 32'd0, 32'(status.ready));
                check_val("status.busy", 32'd1, 32'(status.busy));
            end else begin
                check_val("status.ready", 32'd1, 32'(status.ready));
            end
        end
        check_val("status.busy", 32'd0, 32'(status.busy));
        check_val("status.count", 32'(exp_cnt), 32'(status.count));
        check_val("status.sum", 32'(model_sum(exp_cnt)), 32'(status.sum));
        check_val("status.overflow", 32'(len >= ROM_WORDS), 32'(status.overflow));
        if (exp_cnt > hi_mark) begin
            hi_mark = exp_cnt;
        end
    endtask

    // random reads in the loaded range, then one old address above it
    task automatic playback(input int cnt);
        int                n_rd;
        logic [ROM_AW-1:0] addr;
        logic [ROM_DW-1:0] held;
        n_rd = (cnt > 0) ? NUM_READS : 0;
        held = q;
        for (int k = 0; k <= n_rd; k++) begin
            if (k < n_rd) begin
                addr = ROM_AW'($urandom % cnt);
            end else if (hi_mark > cnt) begin
                addr = ROM_AW'(cnt + int'($urandom % (hi_mark - cnt)));
            end else begin
                break;
            end
            rd_addr = addr;
            // q holds while cen is low
            while (!cen) begin
                check_val("q", 32'(held), 32'(q));
                @(negedge clk);
            end
            @(negedge clk);
            check_val("q", 32'(model[addr]), 32'(q));
            held = q;
        end
    endtask

    // divider enable, high before every CEN_DIV-th clock after reset release
    initial begin
        int clocks;
        clocks = 0;
        @(posedge arst_n);
        forever begin
            @(negedge clk);
            clocks++;
            check_val("cen", 32'(((clocks + 1) % CEN_DIV) == 0), 32'(cen));
        end
    end

    // watchdog, bytes plus scans plus read phases, with margin
    initial begin
        int wd_cycles;
        wd_cycles = 8 + total_bytes() + NUM_ROWS * (1100 + 4)
                  + NUM_ROWS * (NUM_READS + 1) * (2 * CEN_DIV + 1) + 200;
        #(wd_cycles * CLK_PERIOD);
        $display("timeout, the run did not finish within %0d clocks", wd_cycles);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed_val = $urandom(32'h1742ac36);
        hi_mark  = 0;
        arst_n   = 1'b0;
        dl       = '0;
        rd_addr  = '0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        // idle after reset
        check_val("status", 32'd0, 32'(status));
        check_val("q", 32'd0, 32'(q));
        for (int r = 0; r < NUM_ROWS; r++) begin
            download(int'(cases[r].len), cases[r].rnd);
            scan_check(int'(cases[r].len));
            playback((int'(cases[r].len) > ROM_WORDS) ? ROM_WORDS : int'(cases[r].len));
        end
        $display("Regression passed");
        $finish;
    end

endmodule

/* build.f */
verilog/rom_pkg.sv
verilog/rom_prom.sv
verilog/rom_addr_counter.sv
verilog/rom_cen_divider.sv
verilog/rom_sum_accum.sv
verilog/rom_load_ctrl.sv
verilog/rom_subsys_top.sv
testbench/tb_rom_subsys.sv

/* run.sh */
#!/bin/sh
# build the rom subsystem regression with verilator, run it, then scan the log

rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_rom_subsys -f build.f \
    -o sim_rom > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_rom > sim.log 2>&1 || echo "simulator returned a nonzero status"
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0
